// ==== verilog.f ====
+incdir+test
common/aes_pkg.sv
aes_core/aes_sbox.sv
aes_core/aes_key_step.sv
aes_core/aes_round.sv
aes_core/aes_core.sv
hdl/aes_apb_regs.sv
hdl/aes_apb_top.sv
test/aes_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the AES coprocessor testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary -f verilog.f --top-module aes_tb -o aes_tb_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/aes_tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Done: errors found" "$log"; then
	exit 1
fi
exit 0

// ==== test/aes_tb_tasks.svh ====
/*
 * testbench tasks for the AES APB coprocessor
 * - compare tasks for words, blocks and the ready bit
 * - APB write and read, four-word block write and read
 * - completion polling and directed tests
 */
`ifndef AES_TB_TASKS_SVH
`define AES_TB_TASKS_SVH

task automatic check_word(input string name, input word_t exp, input word_t act);
	if (act !== exp) begin
		$display("error: %s expected %h actual %h", name, exp, act);
		errors++;
	end
endtask

task automatic check_block(input string name, input block_t exp, input block_t act);
	if (act !== exp) begin
		$display("error: %s expected %h actual %h", name, exp, act);
		errors++;
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("error: %s expected %b actual %b", name, exp, act);
		errors++;
	end
endtask

task automatic apb_write(input apb_addr_t addr, input word_t data);
	apb_req.psel = 1'b1;
	apb_req.penable = 1'b0;
	apb_req.pwrite = 1'b1;
	apb_req.paddr = addr;
	apb_req.pwdata = data;
	@(posedge clock_clk);
	#drive_delay apb_req.penable = 1'b1;
	@(negedge clock_clk);
	check_bit("apb_write pready", 1'b1, pready);
	@(posedge clock_clk);
	#drive_delay apb_req = '0;
endtask

task automatic apb_read(input apb_addr_t addr, output word_t data);
	apb_req.psel = 1'b1;
	apb_req.penable = 1'b0;
	apb_req.pwrite = 1'b0;
	apb_req.paddr = addr;
	apb_req.pwdata = '0;
	@(posedge clock_clk);
	#drive_delay apb_req.penable = 1'b1;
	// read data is settled by the falling edge of the access phase
	@(negedge clock_clk);
	data = prdata;
	check_bit("apb_read pready", 1'b1, pready);
	@(posedge clock_clk);
	#drive_delay apb_req = '0;
endtask

task automatic write_block(input apb_addr_t base, input block_t b);
	apb_write(base, b[127:96]);
	apb_write(base + 6'd4, b[95:64]);
	apb_write(base + 6'd8, b[63:32]);
	apb_write(base + 6'd12, b[31:0]);
endtask

task automatic read_block(input apb_addr_t base, output block_t b);
	word_t w0;
	word_t w1;
	word_t w2;
	word_t w3;
	apb_read(base, w0);
	apb_read(base + 6'd4, w1);
	apb_read(base + 6'd8, w2);
	apb_read(base + 6'd12, w3);
	b = {w0, w1, w2, w3};
endtask

// poll status until done or the poll limit is reached
task automatic wait_done(input string name);
	word_t st;
	int    polls;
	st = '0;
	polls = 0;
	while (st[1] == 1'b0 && polls < 20) begin
		apb_read(addr_status, st);
		polls++;
	end
	if (st[1] == 1'b0) begin
		$display("%s: encryption did not complete after %0d status polls", name, polls);
		errors++;
	end
endtask

task automatic after_reset();
	word_t  st;
	block_t ct;
	apb_read(addr_status, st);
	check_word("after_reset status", 32'h0, st);
	read_block(addr_ctext0, ct);
	check_block("after_reset ctext", '0, ct);
endtask

task automatic encrypt_vector(input string name, input block_t key, input block_t ptext,
	input block_t ctext);
	block_t ct;
	write_block(addr_key0, key);
	write_block(addr_ptext0, ptext);
	apb_write(addr_ctrl, 32'h1);
	wait_done(name);
	read_block(addr_ctext0, ct);
	check_block(name, ctext, ct);
endtask

// key and plaintext still hold the C.1 vector here
task automatic status_timing();
	word_t  st;
	word_t  w;
	block_t ct;
	apb_write(addr_ctrl, 32'h1);
	// one idle cycle moves the last status read into the first cycle with done set
	@(posedge clock_clk);
	#drive_delay;
	apb_read(addr_status, st);
	check_word("status_timing busy", 32'h1, st);
	apb_read(addr_ctext0, w);
	check_word("status_timing ctext0 while busy", 32'h0, w);
	apb_read(addr_ctext1, w);
	check_word("status_timing ctext1 while busy", 32'h0, w);
	apb_read(addr_ctext2, w);
	check_word("status_timing ctext2 while busy", 32'h0, w);
	// this read samples in the 11th cycle after the start
	apb_read(addr_status, st);
	check_word("status_timing done", 32'h2, st);
	read_block(addr_ctext0, ct);
	check_block("status_timing ctext", c1_ctext, ct);
endtask

task automatic start_while_busy();
	block_t ct;
	write_block(addr_key0, nist_key);
	write_block(addr_ptext0, nist_ptext);
	apb_write(addr_ctrl, 32'h1);
	apb_write(addr_ptext0, 32'h0f1e2d3c);
	apb_write(addr_ctrl, 32'h1);
	wait_done("start_while_busy");
	read_block(addr_ctext0, ct);
	check_block("start_while_busy", nist_ctext, ct);
endtask

task automatic register_readback();
	block_t b;
	word_t  w;
	write_block(addr_key0, 128'h01234567_89abcdef_fedcba98_76543210);
	write_block(addr_ptext0, 128'ha5a5a5a5_5a5a5a5a_c3c3c3c3_3c3c3c3c);
	read_block(addr_key0, b);
	check_block("readback key", 128'h01234567_89abcdef_fedcba98_76543210, b);
	read_block(addr_ptext0, b);
	check_block("readback ptext", 128'ha5a5a5a5_5a5a5a5a_c3c3c3c3_3c3c3c3c, b);
	apb_read(addr_ctrl, w);
	check_word("readback ctrl", 32'h0, w);
	apb_read(6'h38, w);
	check_word("readback unmapped 0x38", 32'h0, w);
	apb_read(6'h3c, w);
	check_word("readback unmapped 0x3c", 32'h0, w);
endtask

`endif

// ==== test/aes_tb.sv ====
/*
 * testbench for the AES-128 APB coprocessor
 * - clock, reset and cycle-count timeout
 * - DUT instance and directed test sequence against FIPS-197 vectors
 */
`timescale 1ns/1ns

module aes_tb
	import aes_pkg::*;
();

	localparam int drive_delay = 5;
	localparam int reset_cycles = 10;
	// six tests of under 60 cycles each, with a wide margin
	localparam int max_cycles = 2000;

	localparam block_t nist_key = 128'h2b7e1516_28aed2a6_abf71588_09cf4f3c;
	localparam block_t nist_ptext = 128'h3243f6a8_885a308d_313198a2_e0370734;
	localparam block_t nist_ctext = 128'h3925841d_02dc09fb_dc118597_196a0b32;
	localparam block_t c1_key = 128'h00010203_04050607_08090a0b_0c0d0e0f;
	localparam block_t c1_ptext = 128'h00112233_44556677_8899aabb_ccddeeff;
	localparam block_t c1_ctext = 128'h69c4e0d8_6a7b0430_d8cdb780_70b4c55a;

	logic     clock_clk;
	logic     reset;
	apb_req_t apb_req;
	word_t    prdata;
	logic     pready;
	int       errors = 0;
	int       cycles = 0;

	aes_apb_top aes_apb_top_i (
		.clock_clk (clock_clk),
		.reset_i   (reset),
		.apb_req_i (apb_req),
		.prdata_o  (prdata),
		.pready_o  (pready)
	);

	`include "aes_tb_tasks.svh"

	initial begin
		clock_clk = 1'b0;
		forever #50 clock_clk = ~clock_clk;
	end

	always @(posedge clock_clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		apb_req = '0;
		repeat (reset_cycles) @(posedge clock_clk);
		#drive_delay reset = 1'b0;

		after_reset();
		encrypt_vector("nist", nist_key, nist_ptext, nist_ctext);
		encrypt_vector("fips_c1", c1_key, c1_ptext, c1_ctext);
		status_timing();
		start_while_busy();
		register_readback();

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== hdl/aes_apb_top.sv ====
/*
 * AES-128 coprocessor top level
 * - APB register block
 * - iterative cipher core
 */
`timescale 1ns/1ns

module aes_apb_top
	import aes_pkg::*;
(
	input  logic     clock_clk,
	input  logic     reset_i,
	input  apb_req_t apb_req_i,
	output word_t    prdata_o,
	output logic     pready_o
);

	aes_req_t aes_req;
	aes_rsp_t aes_rsp;

	aes_apb_regs aes_apb_regs_i (
		.clock_clk (clock_clk),
		.reset_i   (reset_i),
		.apb_req_i (apb_req_i),
		.prdata_o  (prdata_o),
		.pready_o  (pready_o),
		.aes_req_o (aes_req),
		.aes_rsp_i (aes_rsp)
	);

	aes_core aes_core_i (
		.clock_clk (clock_clk),
		.reset_i   (reset_i),
		.req_i     (aes_req),
		.rsp_o     (aes_rsp)
	);

endmodule

// ==== hdl/aes_apb_regs.sv ====
/*
 * APB register file of the AES coprocessor
 * - key and plaintext words, written and read back over APB
 * - start pulse from a ctrl write, status and ciphertext read-back
 */
`timescale 1ns/1ns

module aes_apb_regs
	import aes_pkg::*;
(
	input  logic     clock_clk,
	input  logic     reset_i,
	input  apb_req_t apb_req_i,
	output word_t    prdata_o,
	output logic     pready_o,
	output aes_req_t aes_req_o,
	input  aes_rsp_t aes_rsp_i
);

	block_t key_q;
	block_t ptext_q;
	block_t ctext;
	logic   wr_en;

	// transfer completes in the access phase, no wait states
	assign wr_en = apb_req_i.psel & apb_req_i.penable & apb_req_i.pwrite;
	assign pready_o = 1'b1;

	always_ff @(posedge clock_clk) begin
		if (reset_i) begin
			key_q <= '0;
			ptext_q <= '0;
		end else if (wr_en) begin
			case (apb_req_i.paddr)
				addr_key0: key_q[127:96] <= apb_req_i.pwdata;
				addr_key1: key_q[95:64] <= apb_req_i.pwdata;
				addr_key2: key_q[63:32] <= apb_req_i.pwdata;
				addr_key3: key_q[31:0] <= apb_req_i.pwdata;
				addr_ptext0: ptext_q[127:96] <= apb_req_i.pwdata;
				addr_ptext1: ptext_q[95:64] <= apb_req_i.pwdata;
				addr_ptext2: ptext_q[63:32] <= apb_req_i.pwdata;
				addr_ptext3: ptext_q[31:0] <= apb_req_i.pwdata;
				default: ;
			endcase
		end
	end

	// ctrl is write-only, start lasts for the one access cycle
	assign aes_req_o.start = wr_en && (apb_req_i.paddr == addr_ctrl) && apb_req_i.pwdata[0];
	assign aes_req_o.key = key_q;
	assign aes_req_o.ptext = ptext_q;

	// hide intermediate round state until the result is complete
	assign ctext = aes_rsp_i.done ? aes_rsp_i.state : '0;

	always_comb begin
		prdata_o = '0;
		case (apb_req_i.paddr)
			addr_key0: prdata_o = key_q[127:96];
			addr_key1: prdata_o = key_q[95:64];
			addr_key2: prdata_o = key_q[63:32];
			addr_key3: prdata_o = key_q[31:0];
			addr_ptext0: prdata_o = ptext_q[127:96];
			addr_ptext1: prdata_o = ptext_q[95:64];
			addr_ptext2: prdata_o = ptext_q[63:32];
			addr_ptext3: prdata_o = ptext_q[31:0];
			addr_status: prdata_o = {30'd0, aes_rsp_i.done, aes_rsp_i.busy};
			addr_ctext0: prdata_o = ctext[127:96];
			addr_ctext1: prdata_o = ctext[95:64];
			addr_ctext2: prdata_o = ctext[63:32];
			addr_ctext3: prdata_o = ctext[31:0];
			default: prdata_o = '0;
		endcase
	end

endmodule

// ==== aes_core/aes_core.sv ====
/*
 * iterative AES-128 cipher core
 * - idle/run FSM, round counter and round constant
 * - state and round key registers, one round per clock
 */
`timescale 1ns/1ns

module aes_core
	import aes_pkg::*;
(
	input  logic     clock_clk,
	input  logic     reset_i,
	input  aes_req_t req_i,
	output aes_rsp_t rsp_o
);

	round_state_e state_q;
	block_t       data_q;
	block_t       key_q;
	block_t       round_key;
	block_t       round_out;
	byte_t        rcon_q;
	logic [3:0]   round_q;
	logic         done_q;
	logic         last_round;

	assign last_round = (round_q == 4'(num_rounds));

	// next round key is ready in the same cycle as the round it feeds
	aes_key_step aes_key_step_i (
		.key_i  (key_q),
		.rcon_i (rcon_q),
		.key_o  (round_key)
	);

	aes_round aes_round_i (
		.state_i     (data_q),
		.round_key_i (round_key),
		.last_i      (last_round),
		.state_o     (round_out)
	);

	always_ff @(posedge clock_clk) begin
		if (reset_i) begin
			state_q <= idle;
			data_q <= '0;
			key_q <= '0;
			rcon_q <= rcon_init;
			round_q <= '0;
			done_q <= 1'b0;
		end else begin
			case (state_q)
				idle: begin
					if (req_i.start) begin
						// whitening AddRoundKey happens on the load
						data_q <= req_i.ptext ^ req_i.key;
						key_q <= req_i.key;
						rcon_q <= rcon_init;
						round_q <= 4'd1;
						done_q <= 1'b0;
						state_q <= run;
					end
				end
				run: begin
					data_q <= round_out;
					key_q <= round_key;
					rcon_q <= xtime(rcon_q);
					round_q <= round_q + 4'd1;
					if (last_round) begin
						done_q <= 1'b1;
						state_q <= idle;
					end
				end
				default: state_q <= idle;
			endcase
		end
	end

	assign rsp_o.busy = (state_q == run);
	assign rsp_o.done = done_q;
	assign rsp_o.state = data_q;

endmodule

// ==== aes_core/aes_round.sv ====
/*
 * one AES cipher round
 * - SubBytes over 16 composite-field S-boxes
 * - ShiftRows, MixColumns skipped in the final round, AddRoundKey
 */
`timescale 1ns/1ns

module aes_round
	import aes_pkg::*;
(
	input  block_t state_i,
	input  block_t round_key_i,
	input  logic   last_i,
	output block_t state_o
);

	block_t sub_bytes;
	block_t shifted;
	block_t mixed;

	for (genvar i = 0; i < 16; i++) begin : g_sbox
		aes_sbox aes_sbox_i (
			.in_i  (state_i[127 - 8*i -: 8]),
			.out_o (sub_bytes[127 - 8*i -: 8])
		);
	end

	assign shifted = shift_rows(sub_bytes);

	// final round has no MixColumns
	assign mixed = last_i ? shifted : mix_columns(shifted);

	assign state_o = mixed ^ round_key_i;

endmodule

// ==== aes_core/aes_key_step.sv ====
/*
 * one AES-128 key expansion step
 * - RotWord and SubWord of the last word, round constant
 * - XOR chain through the four words
 */
`timescale 1ns/1ns

module aes_key_step
	import aes_pkg::*;
(
	input  block_t key_i,
	input  byte_t  rcon_i,
	output block_t key_o
);

	word_t rot_word;
	word_t sub_word;
	word_t w0;
	word_t w1;
	word_t w2;
	word_t w3;

	// rotate the last word left by one byte
	assign rot_word = {key_i[23:0], key_i[31:24]};

	for (genvar i = 0; i < 4; i++) begin : g_sbox
		aes_sbox aes_sbox_i (
			.in_i  (rot_word[31 - 8*i -: 8]),
			.out_o (sub_word[31 - 8*i -: 8])
		);
	end

	assign w0 = key_i[127:96] ^ sub_word ^ {rcon_i, 24'd0};
	assign w1 = key_i[95:64] ^ w0;
	assign w2 = key_i[63:32] ^ w1;
	assign w3 = key_i[31:0] ^ w2;

	assign key_o = {w0, w1, w2, w3};

endmodule

// ==== aes_core/aes_sbox.sv ====
/*
 * AES S-box for one byte in composite-field logic
 * - map GF(2^8) to GF((2^4)^2), invert there, map back
 * - affine transform with constant 0x63
 */
`timescale 1ns/1ns

module aes_sbox
	import aes_pkg::*;
(
	input  byte_t in_i,
	output byte_t out_o
);

	logic [3:0] hi;
	logic [3:0] lo;
	logic [3:0] hi_sq;
	logic [3:0] lo_sq;
	logic [3:0] delta;
	logic [3:0] d2;
	logic [3:0] d4;
	logic [3:0] d8;
	logic [3:0] d_inv;
	logic [3:0] out_hi;
	logic [3:0] out_lo;
	byte_t      inv;

	// GF(2^4) product modulo x^4+x+1
	function automatic logic [3:0] gf4_mul(logic [3:0] x, logic [3:0] y);
		logic [3:0] p;
		logic [3:0] t;
		p = 4'd0;
		t = x;
		for (int i = 0; i < 4; i++) begin
			if (y[i]) begin
				p = p ^ t;
			end
			t = {t[2:0], 1'b0} ^ (t[3] ? 4'b0011 : 4'b0000);
		end
		return p;
	endfunction

	// isomorphic mapping, byte becomes hi*x + lo
	assign lo[0] = in_i[0] ^ in_i[4] ^ in_i[5] ^ in_i[6];
	assign lo[1] = in_i[1] ^ in_i[2];
	assign lo[2] = in_i[1] ^ in_i[7];
	assign lo[3] = in_i[2] ^ in_i[4];
	assign hi[0] = in_i[4] ^ in_i[5] ^ in_i[6];
	assign hi[1] = in_i[1] ^ in_i[4] ^ in_i[6] ^ in_i[7];
	assign hi[2] = in_i[2] ^ in_i[3] ^ in_i[5] ^ in_i[7];
	assign hi[3] = in_i[5] ^ in_i[7];

	assign hi_sq = gf4_mul(hi, hi);
	assign lo_sq = gf4_mul(lo, lo);

	// norm of the element, lambda*hi^2 + hi*lo + lo^2
	assign delta = gf4_mul(hi_sq, gf4_lambda) ^ gf4_mul(hi, lo) ^ lo_sq;

	// inverse in GF(2^4) as delta^14, zero stays zero
	assign d2 = gf4_mul(delta, delta);
	assign d4 = gf4_mul(d2, d2);
	assign d8 = gf4_mul(d4, d4);
	assign d_inv = gf4_mul(gf4_mul(d2, d4), d8);

	assign out_hi = gf4_mul(hi, d_inv);
	assign out_lo = gf4_mul(hi ^ lo, d_inv);

	// inverse mapping back to GF(2^8)
	assign inv[0] = out_lo[0] ^ out_hi[0];
	assign inv[1] = out_hi[0] ^ out_hi[1] ^ out_hi[3];
	assign inv[2] = out_hi[0] ^ out_hi[1] ^ out_hi[3] ^ out_lo[1];
	assign inv[3] = out_hi[0] ^ out_hi[1] ^ out_hi[2] ^ out_lo[1];
	assign inv[4] = out_hi[0] ^ out_hi[1] ^ out_hi[3] ^ out_lo[1] ^ out_lo[3];
	assign inv[5] = out_hi[0] ^ out_hi[1] ^ out_lo[2];
	assign inv[6] = out_hi[0] ^ out_hi[3] ^ out_lo[1] ^ out_lo[2] ^ out_lo[3];
	assign inv[7] = out_hi[0] ^ out_hi[1] ^ out_hi[3] ^ out_lo[2];

	// affine transform, each bit folds in the four bits above it cyclically
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			out_o[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8]
				^ inv[(i + 7) % 8] ^ sbox_affine[i];
		end
	end

endmodule

// ==== common/aes_pkg.sv ====
/*
 * shared definitions for the AES-128 APB coprocessor
 * - widths and block types, APB and core request/response structs
 * - register byte offsets, round count, round constant and S-box constants
 * - ShiftRows, xtime and MixColumns helper functions
 */
package aes_pkg;

	typedef logic [7:0]   byte_t;
	typedef logic [31:0]  word_t;
	// byte 0 sits in bits 127:120, column-major as in FIPS-197
	typedef logic [127:0] block_t;
	typedef logic [5:0]   apb_addr_t;

	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		word_t     pwdata;
	} apb_req_t;

	typedef struct packed {
		logic   start;
		block_t key;
		block_t ptext;
	} aes_req_t;

	typedef struct packed {
		logic   busy;
		logic   done;
		block_t state;
	} aes_rsp_t;

	typedef enum logic {idle, run} round_state_e;

	localparam int unsigned num_rounds = 10;
	localparam byte_t rcon_init = 8'h01;

	// composite field constants for the S-box
	localparam logic [3:0] gf4_lambda = 4'he;
	localparam byte_t sbox_affine = 8'h63;

	// register map, word 0 of each group is the most significant word
	localparam apb_addr_t addr_key0 = 6'h00;
	localparam apb_addr_t addr_key1 = 6'h04;
	localparam apb_addr_t addr_key2 = 6'h08;
	localparam apb_addr_t addr_key3 = 6'h0c;
	localparam apb_addr_t addr_ptext0 = 6'h10;
	localparam apb_addr_t addr_ptext1 = 6'h14;
	localparam apb_addr_t addr_ptext2 = 6'h18;
	localparam apb_addr_t addr_ptext3 = 6'h1c;
	localparam apb_addr_t addr_ctrl = 6'h20;
	localparam apb_addr_t addr_status = 6'h24;
	localparam apb_addr_t addr_ctext0 = 6'h28;
	localparam apb_addr_t addr_ctext1 = 6'h2c;
	localparam apb_addr_t addr_ctext2 = 6'h30;
	localparam apb_addr_t addr_ctext3 = 6'h34;

	// multiply by x in GF(2^8) modulo x^8+x^4+x^3+x+1
	function automatic byte_t xtime(byte_t b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	// row r rotates left by r columns
	function automatic block_t shift_rows(block_t s);
		block_t r;
		for (int c = 0; c < 4; c++) begin
			for (int w = 0; w < 4; w++) begin
				r[127 - 8*(4*c + w) -: 8] = s[127 - 8*(4*((c + w) % 4) + w) -: 8];
			end
		end
		return r;
	endfunction

	function automatic block_t mix_columns(block_t s);
		block_t r;
		byte_t  a [4];
		byte_t  t;
		for (int c = 0; c < 4; c++) begin
			for (int i = 0; i < 4; i++) begin
				a[i] = s[127 - 8*(4*c + i) -: 8];
			end
			t = a[0] ^ a[1] ^ a[2] ^ a[3];
			// b_i = a_i ^ t ^ 2*(a_i ^ a_i+1) gives the 2-3-1-1 circulant
			for (int i = 0; i < 4; i++) begin
				r[127 - 8*(4*c + i) -: 8] = a[i] ^ t ^ xtime(a[i] ^ a[(i + 1) % 4]);
			end
		end
		return r;
	endfunction

endpackage
